// File: logic/scroll_pkg.sv
package scroll_pkg;

    // screen geometry
    localparam int tile_cols = 32;
    localparam int tile_rows = 32;
    localparam int h_total = 384;   // pixel clocks per line
    localparam int h_visible = 256;
    localparam int v_total = 264;   // lines per frame
    localparam int v_visible = 224;

    localparam int fixed_cols = 4;     // status area columns, never scrolled
    localparam int rom_wait_max = 3;   // pixel enables allowed for rom_ok

    // tile fetch FSM states
    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_read = 3'd1;
    localparam logic [2:0] st_request = 3'd2;
    localparam logic [2:0] st_wait = 3'd3;
    localparam logic [2:0] st_load = 3'd4;

    typedef struct packed {
        logic [1:0] code_hi;
        logic       vflip;
        logic       hflip;
        logic [3:0] pal;
    } kicker_attr_t;

    // yie board has no palette bits in the attribute
    typedef struct packed {
        logic       hflip;
        logic       vflip;
        logic       spare_a;
        logic       code_hi;
        logic [3:0] spare_b;
    } yie_attr_t;

    typedef union packed {
        kicker_attr_t kicker;
        yie_attr_t    yie;
    } tile_attr_t;

endpackage

// File: logic/video_timing.sv
module video_timing (
    input  logic       clk,
    input  logic       rst,
    output logic       pxl_cen,
    output logic [8:0] hdump,
    output logic [7:0] vdump,
    output logic       lhbl,
    output logic       lvbl
);

    logic [8:0] vcnt;     // full line count, vdump is its low byte
    logic [8:0] h_next;
    logic [8:0] v_next;
    logic       h_wrap;

    assign vdump = vcnt[7:0];
    assign h_wrap = hdump == 9'(scroll_pkg::h_total - 1);

    always_comb begin
        h_next = h_wrap ? 9'd0 : hdump + 9'd1;
        v_next = vcnt;
        if (h_wrap) begin
            // new line
            if (vcnt == 9'(scroll_pkg::v_total - 1)) begin
                v_next = 9'd0;
            end else begin
                v_next = vcnt + 9'd1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pxl_cen <= 1'b0;
            hdump   <= 9'd0;
            vcnt    <= 9'd0;
            lhbl    <= 1'b0;
            lvbl    <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;  // half of clk
            if (pxl_cen) begin
                hdump <= h_next;
                vcnt  <= v_next;
                // blanking follows the position it is registered with
                lhbl  <= h_next < 9'(scroll_pkg::h_visible);
                lvbl  <= v_next < 9'(scroll_pkg::v_visible);
            end
        end
    end

endmodule

// File: logic/tile_vram.sv
module tile_vram (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [10:0]            cpu_addr,
    input  logic [7:0]             cpu_dout,
    input  logic                   cpu_rnw,
    input  logic                   vram_cs,
    output logic [7:0]             vram_dout,
    input  logic [9:0]             rd_addr,
    output logic [7:0]             code,
    output scroll_pkg::tile_attr_t attr
);

    logic [7:0] attr_mem [scroll_pkg::tile_cols * scroll_pkg::tile_rows];
    logic [7:0] code_mem [scroll_pkg::tile_cols * scroll_pkg::tile_rows];
    logic [7:0] cpu_attr_q;
    logic [7:0] cpu_code_q;
    logic       bank_q;   // bank of the last cpu read
    logic       we;

    assign we = vram_cs & ~cpu_rnw;
    assign vram_dout = bank_q ? cpu_code_q : cpu_attr_q;

    always_ff @(posedge clk) begin
        if (we && !cpu_addr[10]) begin
            attr_mem[cpu_addr[9:0]] <= cpu_dout;
        end
        if (we && cpu_addr[10]) begin
            code_mem[cpu_addr[9:0]] <= cpu_dout;
        end
        cpu_attr_q <= attr_mem[cpu_addr[9:0]];
        cpu_code_q <= code_mem[cpu_addr[9:0]];
    end

    // video port, both banks at the same index
    always_ff @(posedge clk) begin
        code <= code_mem[rd_addr];
        attr <= attr_mem[rd_addr];
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank_q <= 1'b0;
        end else begin
            bank_q <= cpu_addr[10];
        end
    end

endmodule

// File: logic/tile_fetch_ctrl.sv
module tile_fetch_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic [8:0]             hdump,
    input  logic [7:0]             vdump,
    input  logic [7:0]             cpu_dout,
    input  logic                   vscr_cs,
    input  logic                   alt_layout,
    output logic [7:0]             vscr_dout,
    output logic [9:0]             rd_addr,
    input  logic [7:0]             code,
    input  scroll_pkg::tile_attr_t attr,
    output logic [12:0]            rom_addr,
    input  logic                   rom_ok,
    output logic                   load,
    output logic                   blank,
    output logic                   hflip,
    output logic [3:0]             pal
);

    logic [7:0] scroll;
    logic [7:0] eff_row;
    logic [2:0] state;
    logic [1:0] wait_cnt;
    logic [2:0] row_lo;       // row inside the tile, latched with rd_addr
    logic [1:0] code_hi;
    logic       vflip;
    logic       attr_hflip;
    logic [3:0] attr_pal;
    logic       start;
    logic       deadline;
    logic       got_ok;

    assign vscr_dout = eff_row;

    // one attribute byte, two board layouts
    always_comb begin
        if (alt_layout) begin
            code_hi    = {1'b0, attr.yie.code_hi};
            vflip      = attr.yie.vflip;
            attr_hflip = attr.yie.hflip;
            attr_pal   = 4'd0;
        end else begin
            code_hi    = attr.kicker.code_hi;
            vflip      = attr.kicker.vflip;
            attr_hflip = attr.kicker.hflip;
            attr_pal   = attr.kicker.pal;
        end
    end

    assign start = state == scroll_pkg::st_idle && pxl_cen && hdump[2:0] == 3'd0;
    // third pixel enable of the wait falls on hdump[2:0]==4
    assign deadline = state == scroll_pkg::st_wait
                      && wait_cnt == 2'(scroll_pkg::rom_wait_max - 1);
    // ok may linger from the previous address for a clk
    assign got_ok = rom_ok && wait_cnt != 2'd0;

    assign load = hdump[2:0] == 3'd4 && (state == scroll_pkg::st_load || deadline);
    assign blank = deadline && !rom_ok;   // no data, tile shows colour 0

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            scroll  <= 8'd0;
            eff_row <= 8'd0;
        end else begin
            if (vscr_cs) scroll <= cpu_dout;
            if (hdump < 9'(scroll_pkg::fixed_cols * 8)) begin
                eff_row <= vdump;
            end else begin
                eff_row <= vdump + scroll + 8'd1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= scroll_pkg::st_idle;
            wait_cnt <= 2'd0;
        end else begin
            case (state)
                scroll_pkg::st_idle: begin
                    if (start) state <= scroll_pkg::st_read;
                end
                scroll_pkg::st_read: begin
                    state <= scroll_pkg::st_request;  // vram latches code and attr
                end
                scroll_pkg::st_request: begin
                    wait_cnt <= 2'd0;
                    state    <= scroll_pkg::st_wait;
                end
                scroll_pkg::st_wait: begin
                    if (pxl_cen && deadline) begin
                        state <= scroll_pkg::st_idle;   // loaded blank or just in time
                    end else if (got_ok) begin
                        state <= scroll_pkg::st_load;
                    end else if (pxl_cen) begin
                        wait_cnt <= wait_cnt + 2'd1;
                    end
                end
                scroll_pkg::st_load: begin
                    if (pxl_cen && hdump[2:0] == 3'd4) state <= scroll_pkg::st_idle;
                end
                default: state <= scroll_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rd_addr <= {eff_row[7:3], hdump[7:3]};
            row_lo  <= eff_row[2:0];
        end
        if (state == scroll_pkg::st_request) begin
            rom_addr <= {code_hi, code, row_lo ^ {3{vflip}}};  // 2+8+3
            hflip    <= attr_hflip;
            pal      <= attr_pal;
        end
    end

endmodule

// File: logic/pixel_shifter.sv
module pixel_shifter (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        load,
    input  logic        blank,
    input  logic        hflip,
    input  logic [3:0]  pal,
    input  logic [31:0] rom_data,
    output logic [7:0]  pal_addr
);

    logic [31:0] ordered;
    logic [31:0] sr;
    logic [3:0]  pal_q;
    logic [3:0]  nibble;
    logic        hflip_q;
    logic        blank_q;

    // position 0 goes to the top nibble
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            ordered[28 - 4 * k +: 4] = rom_data[4 * k +: 4];
        end
    end

    assign nibble = hflip_q ? sr[3:0] : sr[31:28];  // flipped tiles start at position 7
    assign pal_addr = blank_q ? 8'd0 : {pal_q, nibble};

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (load) begin
                sr    <= ordered;
                pal_q <= pal;
            end else begin
                sr <= hflip_q ? sr >> 4 : sr << 4;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hflip_q <= 1'b0;
            blank_q <= 1'b0;
        end else if (pxl_cen && load) begin
            hflip_q <= hflip;
            blank_q <= blank;  // held for the whole tile
        end
    end

endmodule

// File: logic/palette_prom.sv
module palette_prom (
    input  logic       clk,
    input  logic       pxl_cen,
    input  logic       prog_en,
    input  logic [7:0] prog_addr,
    input  logic [3:0] prog_data,
    input  logic [7:0] rd_addr,
    output logic [3:0] pxl
);

    logic [3:0] mem [256];

    always_ff @(posedge clk) begin
        if (prog_en) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // read side runs at pixel rate
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pxl <= mem[rd_addr];
        end
    end

endmodule

// File: logic/scroll_layer.sv
module scroll_layer (
    input  logic        clk,
    input  logic        rst,
    input  logic [10:0] cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        cpu_rnw,
    input  logic        vram_cs,
    input  logic        vscr_cs,
    output logic [7:0]  vram_dout,
    output logic [7:0]  vscr_dout,
    input  logic        alt_layout,
    input  logic        prog_en,
    input  logic [7:0]  prog_addr,
    input  logic [3:0]  prog_data,
    output logic [12:0] rom_addr,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output logic [3:0]  pxl,
    output logic [8:0]  hdump,
    output logic [7:0]  vdump,
    output logic        lhbl,
    output logic        lvbl
);

    logic                   pxl_cen;
    logic [9:0]             rd_addr;
    logic [7:0]             code;
    scroll_pkg::tile_attr_t attr;
    logic                   load;
    logic                   blank;
    logic                   hflip;
    logic [3:0]             pal;
    logic [7:0]             pal_addr;

    video_timing video_timing_inst (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .lhbl    (lhbl),
        .lvbl    (lvbl)
    );

    tile_vram tile_vram_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_rnw   (cpu_rnw),
        .vram_cs   (vram_cs),
        .vram_dout (vram_dout),
        .rd_addr   (rd_addr),
        .code      (code),
        .attr      (attr)
    );

    // tile c is read at hdump 8c..8c+3 and loaded at 8c+4
    tile_fetch_ctrl tile_fetch_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .hdump      (hdump),
        .vdump      (vdump),
        .cpu_dout   (cpu_dout),
        .vscr_cs    (vscr_cs),
        .alt_layout (alt_layout),
        .vscr_dout  (vscr_dout),
        .rd_addr    (rd_addr),
        .code       (code),
        .attr       (attr),
        .rom_addr   (rom_addr),
        .rom_ok     (rom_ok),
        .load       (load),
        .blank      (blank),
        .hflip      (hflip),
        .pal        (pal)
    );

    pixel_shifter pixel_shifter_inst (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .load     (load),
        .blank    (blank),
        .hflip    (hflip),
        .pal      (pal),
        .rom_data (rom_data),
        .pal_addr (pal_addr)
    );

    // pixel k of tile c is registered on the pxl_cen at hdump 8c+5+k
    palette_prom palette_prom_inst (
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rd_addr   (pal_addr),
        .pxl       (pxl)
    );

endmodule

// File: bench/gfx_rom_model.sv
module gfx_rom_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        withhold,   // never raise rom_ok while high
    input  logic [12:0] rom_addr,
    output logic [31:0] rom_data,
    output logic        rom_ok
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] words [8192];
    logic [12:0] last_addr;
    logic [1:0]  age;   // clks since the address last changed
    int          seed;

    // random table mixed with the address bits
    initial begin
        seed = 32'h519a_16f4;
        for (int a = 0; a < 8192; a++) begin
            words[a] = $random(seed) ^ {a[12:0], 19'd0};
        end
    end

    assign rom_data = words[rom_addr];
    // two clks after a new address, one pixel enable
    assign rom_ok = !withhold && rom_addr == last_addr && age == 2'd2;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            last_addr <= 13'd0;
            age       <= 2'd0;
        end else if (rom_addr != last_addr) begin
            last_addr <= rom_addr;
            age       <= 2'd0;
        end else if (age != 2'd2) begin
            age <= age + 2'd1;
        end
    end

endmodule

// File: bench/scroll_layer_tb.sv
module scroll_layer_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst;
    logic [10:0] cpu_addr;
    logic [7:0]  cpu_dout;
    logic        cpu_rnw;
    logic        vram_cs;
    logic        vscr_cs;
    logic [7:0]  vram_dout;
    logic [7:0]  vscr_dout;
    logic        alt_layout;
    logic        prog_en;
    logic [7:0]  prog_addr;
    logic [3:0]  prog_data;
    logic [12:0] rom_addr;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic [3:0]  pxl;
    logic [8:0]  hdump;
    logic [7:0]  vdump;
    logic        lhbl;
    logic        lvbl;
    logic        withhold;
    int          seed;

    scroll_layer scroll_layer_inst (
        .clk        (clk),
        .rst        (rst),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .cpu_rnw    (cpu_rnw),
        .vram_cs    (vram_cs),
        .vscr_cs    (vscr_cs),
        .vram_dout  (vram_dout),
        .vscr_dout  (vscr_dout),
        .alt_layout (alt_layout),
        .prog_en    (prog_en),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .pxl        (pxl),
        .hdump      (hdump),
        .vdump      (vdump),
        .lhbl       (lhbl),
        .lvbl       (lvbl)
    );

    gfx_rom_model gfx_rom_inst (
        .clk      (clk),
        .rst      (rst),
        .withhold (withhold),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_hpos(input string name, input logic [8:0] exp, input logic [8:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_pixel(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_attr(input string name, input scroll_pkg::tile_attr_t exp,
                              input scroll_pkg::tile_attr_t act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_rom_addr(input string name, input logic [12:0] exp,
                                  input logic [12:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic logic at_pos(input int h, input int v);
        return int'(hdump) == h && int'(vdump) == v;
    endfunction

    // polls on falling edges and gives up after a bit more than a frame
    task automatic wait_pos(input int h, input int v);
        int n;
        n = 0;
        while (!at_pos(h, v) && n < 2 * scroll_pkg::h_total * scroll_pkg::v_total + 16) begin
            @(negedge clk);
            n++;
        end
        if (!at_pos(h, v)) begin
            $display("timed out waiting for hdump %0d on line %0d", h, v);
            abort_run();
        end
    endtask

    task automatic cpu_write(input logic [10:0] addr, input logic [7:0] data);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_rnw  = 1'b0;
        vram_cs  = 1'b1;
        @(negedge clk);
        vram_cs = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    task automatic cpu_read(input logic [10:0] addr, output logic [7:0] data);
        cpu_addr = addr;
        cpu_rnw  = 1'b1;
        vram_cs  = 1'b1;
        @(negedge clk);
        data    = vram_dout;   // one clk after the address
        vram_cs = 1'b0;
    endtask

    task automatic set_scroll(input logic [7:0] s);
        cpu_dout = s;
        vscr_cs  = 1'b1;
        @(negedge clk);
        vscr_cs = 1'b0;
    endtask

    function automatic logic [3:0] pal_value(input logic [7:0] addr);
        return addr[7:4] ^ addr[3:0] ^ 4'h5;
    endfunction

    task automatic load_palette();
        for (int a = 0; a < 256; a++) begin
            prog_en   = 1'b1;
            prog_addr = 8'(a);
            prog_data = pal_value(8'(a));
            @(negedge clk);
        end
        prog_en = 1'b0;
    endtask

    // code_hi and code followed by the row inside the tile
    function automatic logic [12:0] expected_rom_addr(input logic [7:0] row,
            input logic [7:0] code, input scroll_pkg::tile_attr_t attr, input logic alt);
        logic [2:0] line;
        if (alt) begin
            line = attr.yie.vflip ? ~row[2:0] : row[2:0];
            return {1'b0, attr.yie.code_hi, code, line};
        end else begin
            line = attr.kicker.vflip ? ~row[2:0] : row[2:0];
            return {attr.kicker.code_hi, code, line};
        end
    endfunction

    function automatic logic [3:0] expected_pixel(input logic [31:0] word,
            input scroll_pkg::tile_attr_t attr, input logic alt, input int k);
        logic [3:0] pal;
        logic       flip;
        int         pos;
        pal  = alt ? 4'd0 : attr.kicker.pal;   // yie has no palette bits
        flip = alt ? attr.yie.hflip : attr.kicker.hflip;
        pos  = flip ? 7 - k : k;
        return pal_value({pal, word[4 * pos +: 4]});
    endfunction

    // places one tile and checks its rom address and eight pixels on line v
    task automatic verify_tile(input logic [7:0] v, input int c, input logic [7:0] code,
                               input scroll_pkg::tile_attr_t attr, input logic blanked);
        logic [12:0] addr;
        logic [31:0] word;
        logic [3:0]  exp;
        int          k;
        addr = expected_rom_addr(v, code, attr, alt_layout);
        cpu_write({1'b1, v[7:3], c[4:0]}, code);
        cpu_write({1'b0, v[7:3], c[4:0]}, attr);
        wait_pos(0, v);
        wait_pos(8 * c + 3, v);
        check_rom_addr("rom_addr", addr, rom_addr);
        word = gfx_rom_inst.words[addr];
        for (k = 0; k < 8; k++) begin
            wait_pos(8 * c + 6 + k, v);   // registered on the enable at 8c+5+k
            if (blanked) begin
                exp = pal_value(8'd0);
            end else begin
                exp = expected_pixel(word, attr, alt_layout, k);
            end
            check_pixel($sformatf("pxl col %0d pixel %0d", c, k), exp, pxl);
        end
    endtask

    task automatic test_reset_state();
        check_hpos("hdump", 9'd0, hdump);
        check_byte("vdump", 8'd0, vdump);
        check_bit("lhbl", 1'b0, lhbl);
        check_bit("lvbl", 1'b0, lvbl);
    endtask

    // line wrap, blanking edges and one position step per two clks
    task automatic test_timing();
        wait_pos(383, 40);
        check_bit("lhbl", 1'b0, lhbl);
        check_bit("lvbl", 1'b1, lvbl);
        @(negedge clk);
        check_hpos("hdump", 9'd383, hdump);
        @(negedge clk);
        check_hpos("hdump", 9'd0, hdump);
        check_byte("vdump", 8'd41, vdump);
        check_bit("lhbl", 1'b1, lhbl);
        wait_pos(255, 41);
        check_bit("lhbl", 1'b1, lhbl);
        wait_pos(256, 41);
        check_bit("lhbl", 1'b0, lhbl);
        wait_pos(10, 223);
        check_bit("lvbl", 1'b1, lvbl);
        wait_pos(10, 224);
        check_bit("lvbl", 1'b0, lvbl);
    endtask

    task automatic test_vram_rw();
        logic [9:0]             idx;
        logic [7:0]             code;
        logic [7:0]             got;
        scroll_pkg::tile_attr_t attr_exp;
        scroll_pkg::tile_attr_t attr_got;
        for (int i = 0; i < 16; i++) begin
            idx      = 10'($random(seed));
            attr_exp = 8'($random(seed));
            code     = 8'($random(seed));
            cpu_write({1'b0, idx}, attr_exp);
            cpu_write({1'b1, idx}, code);
            cpu_read({1'b0, idx}, got);
            attr_got = got;
            check_attr("vram_dout attr", attr_exp, attr_got);
            cpu_read({1'b1, idx}, got);
            check_byte("vram_dout code", code, got);
            attr_exp = 8'($random(seed));
            cpu_write({1'b0, idx}, attr_exp);   // other bank must keep its byte
            cpu_read({1'b1, idx}, got);
            check_byte("vram_dout code", code, got);
            cpu_read({1'b0, idx}, got);
            attr_got = got;
            check_attr("vram_dout attr", attr_exp, attr_got);
        end
    endtask

    task automatic test_scroll();
        logic [7:0] s;
        s = 8'($random(seed));
        set_scroll(s);
        wait_pos(20, 60);
        check_byte("vscr_dout", 8'd60, vscr_dout);
        wait_pos(31, 60);
        check_byte("vscr_dout", 8'd60, vscr_dout);
        wait_pos(33, 60);
        check_byte("vscr_dout", 8'd60 + s + 8'd1, vscr_dout);
        wait_pos(200, 60);
        check_byte("vscr_dout", 8'd60 + s + 8'd1, vscr_dout);
        set_scroll(8'hff);   // row follows vdump from here on
        wait_pos(200, 61);
        check_byte("vscr_dout", 8'd61, vscr_dout);
    endtask

    task automatic test_pixel_order();
        verify_tile(8'd80, 2, 8'($random(seed)), 8'($random(seed)) & 8'hcf, 1'b0);
        verify_tile(8'd81, 13, 8'($random(seed)), 8'($random(seed)) & 8'hcf, 1'b0);
    endtask

    task automatic test_flips();
        verify_tile(8'd82, 9, 8'($random(seed)), (8'($random(seed)) & 8'hcf) | 8'h10, 1'b0);
        verify_tile(8'd85, 9, 8'($random(seed)), (8'($random(seed)) & 8'hcf) | 8'h20, 1'b0);
        verify_tile(8'd86, 20, 8'($random(seed)), 8'($random(seed)) | 8'h30, 1'b0);
    endtask

    task automatic test_yie();
        alt_layout = 1'b1;
        verify_tile(8'd90, 11, 8'($random(seed)), 8'hd7, 1'b0);
        verify_tile(8'd91, 5, 8'($random(seed)), 8'h2b, 1'b0);
        alt_layout = 1'b0;
    endtask

    task automatic test_missing_rom();
        withhold = 1'b1;
        verify_tile(8'd100, 7, 8'($random(seed)), 8'h5a, 1'b1);
        withhold = 1'b0;
        verify_tile(8'd101, 7, 8'($random(seed)), 8'h5a, 1'b0);   // recovers
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        cpu_addr   = 11'd0;
        cpu_dout   = 8'd0;
        cpu_rnw    = 1'b1;
        vram_cs    = 1'b0;
        vscr_cs    = 1'b0;
        alt_layout = 1'b0;
        prog_en    = 1'b0;
        prog_addr  = 8'd0;
        prog_data  = 4'd0;
        withhold   = 1'b0;
        seed       = 32'h519a_16f4;
        repeat (5) @(posedge clk);
        @(negedge clk);
        test_reset_state();
        rst = 1'b0;

        test_timing();
        test_vram_rw();
        test_scroll();
        load_palette();
        test_pixel_order();
        test_flips();
        test_yie();
        test_missing_rom();

        $display("** PASS **");
        $finish;
    end

endmodule

// File: vlog.f
logic/scroll_pkg.sv
logic/video_timing.sv
logic/tile_vram.sv
logic/tile_fetch_ctrl.sv
logic/pixel_shifter.sv
logic/palette_prom.sv
logic/scroll_layer.sv
bench/gfx_rom_model.sv
bench/scroll_layer_tb.sv

// File: Makefile
TB = scroll_layer_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f vlog.f --top-module scroll_layer
	verilator --lint-only --timing --timescale 1ns/100ps -f vlog.f --top-module $(TB)

sim:
	verilator --binary --timing --timescale 1ns/100ps -f vlog.f --top-module $(TB) -Mdir obj_dir
	./obj_dir/V$(TB)

clean:
	rm -rf obj_dir
